//--- hw/vic_pkg.sv
package vic_pkg;

    // ----------------------------------------------------------------------
    // chip types and their raster geometry
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        CHIP6567R8   = 2'd0,
        CHIP6567R56A = 2'd1,
        CHIP6569R1   = 2'd2,
        CHIP6569R5   = 2'd3
    } chip_t;

    // last pixel of a line and last line of a frame
    typedef struct packed {
        logic [9:0] raster_x_max;
        logic [8:0] raster_y_max;
    } chip_limits_t;

    // where the beam is, down to the 4x dot tick
    typedef struct packed {
        logic [4:0] phase_tick;
        logic [9:0] raster_x;
        logic [6:0] cycle_num;
        logic [8:0] raster_line;
    } raster_pos_t;

    // control bits the arbiter needs from the register slice
    typedef struct packed {
        logic       den;
        logic [2:0] yscroll;
        logic [8:0] raster_cmp;
        logic       erst;
    } vic_ctrl_t;

    // ----------------------------------------------------------------------
    // tick positions inside one 32 tick phi cycle
    // ----------------------------------------------------------------------
    localparam int         TICKS_PER_CYCLE = 32;
    localparam logic [4:0] PHI_HIGH_TICK   = 5'd16;
    localparam logic [4:0] BADLINE_TICK    = 5'd1;
    localparam logic [4:0] IRQ_TICK        = 5'd8;
    // cpu write data is stable here
    localparam logic [4:0] DAV_TICK        = 5'd28;
    localparam logic [4:0] PHASE_END_TICK  = 5'd31;

    // display window lines and char fetch cycles
    localparam logic [8:0] BADLINE_FIRST       = 9'd48;
    localparam logic [8:0] BADLINE_LAST        = 9'd247;
    localparam logic [6:0] BA_CHAR_FIRST_CYCLE = 7'd12;
    localparam logic [6:0] BA_CHAR_LAST_CYCLE  = 7'd54;

    // register offsets within the chip
    localparam logic [5:0] REG_CTRL1  = 6'h11;
    localparam logic [5:0] REG_RASTER = 6'h12;
    localparam logic [5:0] REG_IRQ    = 6'h19;
    localparam logic [5:0] REG_IRQ_EN = 6'h1A;

    // ntsc parts have longer lines and fewer of them
    function automatic chip_limits_t chip_limits(input chip_t chip);
        chip_limits_t lim;
        case (chip)
            CHIP6567R8:   lim = '{raster_x_max: 10'd519, raster_y_max: 9'd262};
            CHIP6567R56A: lim = '{raster_x_max: 10'd511, raster_y_max: 9'd261};
            default:      lim = '{raster_x_max: 10'd503, raster_y_max: 9'd311};
        endcase
        return lim;
    endfunction

endpackage

//--- hw/phase_gen.sv
`timescale 1ns/1ps

module phase_gen
    import vic_pkg::*;
(
    input  logic       clk_dot4x,
    input  logic       rst,
    output logic [4:0] phase_tick_o,
    output logic       phi_o
);

    // ----------------------------------------------------------------------
    // single time base for the whole chip
    // ----------------------------------------------------------------------
    // ticks 0..15 are the vic half (phi low)
    // ticks 16..31 belong to the cpu (phi high)
    // every fourth tick (low bits 3) marks the end of one dot
    logic [4:0] tick_next;

    // explicit wrap so a different cycle length stays a one line change
    assign tick_next = (phase_tick_o == 5'(TICKS_PER_CYCLE - 1)) ? 5'd0
                                                                 : phase_tick_o + 5'd1;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            // start of a cycle with phi low
            phase_tick_o <= 5'd0;
            phi_o        <= 1'b0;
        end else begin
            phase_tick_o <= tick_next;
            // decode from the next count so phi lines up with the tick
            phi_o        <= (tick_next >= PHI_HIGH_TICK);
        end
    end

endmodule

//--- hw/raster_counter.sv
`timescale 1ns/1ps

module raster_counter
    import vic_pkg::*;
(
    input  logic        clk_dot4x,
    input  logic        rst,
    input  chip_t       chip_i,
    input  logic [4:0]  phase_tick_i,
    output raster_pos_t pos_o
);

    // ----------------------------------------------------------------------
    // beam position counters
    // ----------------------------------------------------------------------
    chip_limits_t lim;
    logic         dot_end;
    logic         line_end;
    logic [9:0]   raster_x_q;
    logic [8:0]   raster_line_q;

    // limits follow the chip input directly
    // it only changes while the chip is held in reset
    assign lim = chip_limits(chip_i);

    // last of the four ticks that make up one dot
    assign dot_end = (phase_tick_i[1:0] == 2'b11);

    // compare with >= so an out of range x after a chip swap still wraps
    assign line_end = (raster_x_q >= lim.raster_x_max);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x_q    <= 10'd0;
            raster_line_q <= 9'd0;
        end else if (dot_end) begin
            if (line_end) begin
                raster_x_q <= 10'd0;
                // next line or back to the top of the frame
                if (raster_line_q >= lim.raster_y_max) begin
                    raster_line_q <= 9'd0;
                end else begin
                    raster_line_q <= raster_line_q + 9'd1;
                end
            end else begin
                raster_x_q <= raster_x_q + 10'd1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // position bundle for the register slice and the arbiter
    // ----------------------------------------------------------------------
    assign pos_o.phase_tick  = phase_tick_i;
    assign pos_o.raster_x    = raster_x_q;
    // eight pixels per cycle
    assign pos_o.cycle_num   = raster_x_q[9:3];
    assign pos_o.raster_line = raster_line_q;

endmodule

//--- hw/vic_registers.sv
`timescale 1ns/1ps

module vic_registers
    import vic_pkg::*;
(
    input  logic        clk_dot4x,
    input  logic        rst,
    input  raster_pos_t pos_i,
    input  logic        phi_i,
    input  logic        ce_i,
    input  logic        rw_i,
    input  logic [5:0]  adi_i,
    input  logic [7:0]  dbi_i,
    output logic [7:0]  dbo_o,
    output vic_ctrl_t   ctrl_o,
    output logic        irq_o
);

    // ----------------------------------------------------------------------
    // register storage
    // ----------------------------------------------------------------------
    // low seven bits of $d011 as the cpu wrote them
    logic [6:0] ctrl1_q;
    logic [8:0] raster_cmp_q;
    logic       erst_q;
    logic       irst_q;
    // raster match already fired on this line
    logic       triggered_q;

    logic       wr_stb;
    logic       irq_slot;
    logic       raster_match;

    // cpu write lands on the data valid tick of the phi high half
    assign wr_stb = (pos_i.phase_tick == DAV_TICK) && !ce_i && !rw_i;

    // raster compare is sampled once per cycle in the vic half
    assign irq_slot     = (pos_i.phase_tick == IRQ_TICK) && !phi_i;
    assign raster_match = (pos_i.raster_line == raster_cmp_q);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ctrl1_q      <= 7'd0;
            raster_cmp_q <= 9'd0;
            erst_q       <= 1'b0;
        end else if (wr_stb) begin
            case (adi_i)
                REG_CTRL1: begin
                    // bit 7 goes to the compare msb
                    raster_cmp_q[8] <= dbi_i[7];
                    ctrl1_q         <= dbi_i[6:0];
                end
                REG_RASTER: raster_cmp_q[7:0] <= dbi_i;
                REG_IRQ_EN: erst_q <= dbi_i[0];
                default: ;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // raster interrupt latch
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            irst_q      <= 1'b0;
            triggered_q <= 1'b0;
        end else begin
            if (!raster_match) begin
                // rearm as soon as line and compare differ
                triggered_q <= 1'b0;
            end else if (irq_slot && !triggered_q) begin
                triggered_q <= 1'b1;
                irst_q      <= 1'b1;
            end
            // writing a one acknowledges the latch
            if (wr_stb && (adi_i == REG_IRQ) && dbi_i[0]) begin
                irst_q <= 1'b0;
            end
        end
    end

    // latch keeps running even with the enable off
    assign irq_o = irst_q & erst_q;

    // read mux straight from the address lines
    always_comb begin
        case (adi_i)
            REG_CTRL1:  dbo_o = {pos_i.raster_line[8], ctrl1_q};
            REG_RASTER: dbo_o = pos_i.raster_line[7:0];
            REG_IRQ:    dbo_o = {irq_o, 6'b111111, irst_q};
            REG_IRQ_EN: dbo_o = {7'b1111111, erst_q};
            // unmapped addresses float high
            default:    dbo_o = 8'hFF;
        endcase
    end

    assign ctrl_o.den        = ctrl1_q[4];
    assign ctrl_o.yscroll    = ctrl1_q[2:0];
    assign ctrl_o.raster_cmp = raster_cmp_q;
    assign ctrl_o.erst       = erst_q;

endmodule

//--- hw/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
    import vic_pkg::*;
#(
    parameter int BA_LEAD_PHASES = 3
) (
    input  logic        clk_dot4x,
    input  logic        rst,
    input  raster_pos_t pos_i,
    input  logic        phi_i,
    input  vic_ctrl_t   ctrl_i,
    output logic        ba_o,
    output logic        aec_o
);

    // ----------------------------------------------------------------------
    // badline detection
    // ----------------------------------------------------------------------
    logic                      allow_bad_lines;
    logic                      allow_next;
    logic                      badline;
    logic                      badline_next;
    logic                      in_char_window;
    logic                      phase_end_hi;
    logic [4:0]                tick_plus1;
    logic                      phi_next;
    // one stage per phase end that ba has been low
    logic [BA_LEAD_PHASES-1:0] ba_casc;

    // den counts only on line 48 and the window closes at 248
    always_comb begin
        allow_next = allow_bad_lines;
        if (ctrl_i.den && (pos_i.raster_line == BADLINE_FIRST)) begin
            allow_next = 1'b1;
        end
        if (pos_i.raster_line == BADLINE_LAST + 9'd1) begin
            allow_next = 1'b0;
        end
    end

    // badline sees a set made on the same tick
    assign badline_next = allow_next
                       && (pos_i.raster_line >= BADLINE_FIRST)
                       && (pos_i.raster_line <= BADLINE_LAST)
                       && (pos_i.raster_line[2:0] == ctrl_i.yscroll);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            allow_bad_lines <= 1'b0;
            badline         <= 1'b0;
        end else if (pos_i.phase_tick == BADLINE_TICK) begin
            allow_bad_lines <= allow_next;
            badline         <= badline_next;
        end
    end

    // ----------------------------------------------------------------------
    // ba and the aec cascade
    // ----------------------------------------------------------------------
    // char fetch cycles plus the three cycle lead in front of them
    assign in_char_window = (pos_i.cycle_num >= BA_CHAR_FIRST_CYCLE)
                         && (pos_i.cycle_num <= BA_CHAR_LAST_CYCLE);

    assign phase_end_hi = (pos_i.phase_tick == PHASE_END_TICK) && phi_i;

    // phi as it will be after this edge so aec tracks it tick for tick
    assign tick_plus1 = pos_i.phase_tick + 5'd1;
    assign phi_next   = (tick_plus1 >= PHI_HIGH_TICK);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba_o    <= 1'b1;
            ba_casc <= '1;
            aec_o   <= 1'b0;
        end else begin
            // ba is active low
            ba_o <= !(badline && in_char_window);
            if (phase_end_hi) begin
                ba_casc[0] <= ba_o;
                for (int k = 1; k < BA_LEAD_PHASES; k++) begin
                    ba_casc[k] <= ba_casc[k-1] | ba_o;
                end
            end
            // cpu keeps the bus until the last stage has seen ba low
            aec_o <= phi_next & (ba_o | ba_casc[BA_LEAD_PHASES-1]);
        end
    end

endmodule

//--- hw/vic_timing_top.sv
`timescale 1ns/1ps

module vic_timing_top
    import vic_pkg::*;
#(
    parameter int BA_LEAD_PHASES = 3
) (
    input  logic        clk_dot4x,
    input  logic        rst,
    input  chip_t       chip_i,
    input  logic        ce_i,
    input  logic        rw_i,
    input  logic [5:0]  adi_i,
    input  logic [7:0]  dbi_i,
    output logic [7:0]  dbo_o,
    output logic        phi_o,
    output logic        irq_o,
    output logic        ba_o,
    output logic        aec_o,
    output raster_pos_t pos_o
);

    // ----------------------------------------------------------------------
    // internal nets
    // ----------------------------------------------------------------------
    logic [4:0]  phase_tick;
    logic        phi;
    raster_pos_t pos;
    vic_ctrl_t   ctrl;

    phase_gen u_phase_gen (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .phase_tick_o (phase_tick),
        .phi_o        (phi)
    );

    raster_counter u_raster_counter (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .chip_i       (chip_i),
        .phase_tick_i (phase_tick),
        .pos_o        (pos)
    );

    vic_registers u_vic_registers (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .pos_i     (pos),
        .phi_i     (phi),
        .ce_i      (ce_i),
        .rw_i      (rw_i),
        .adi_i     (adi_i),
        .dbi_i     (dbi_i),
        .dbo_o     (dbo_o),
        .ctrl_o    (ctrl),
        .irq_o     (irq_o)
    );

    // arbiter sees the same position bundle as the registers
    bus_arbiter #(
        .BA_LEAD_PHASES (BA_LEAD_PHASES)
    ) u_bus_arbiter (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .pos_i     (pos),
        .phi_i     (phi),
        .ctrl_i    (ctrl),
        .ba_o      (ba_o),
        .aec_o     (aec_o)
    );

    assign phi_o = phi;
    assign pos_o = pos;

endmodule

//--- verification/vic_timing_props.sv
`timescale 1ns/1ps

module vic_timing_props
    import vic_pkg::*;
(
    input logic        clk_dot4x,
    input logic        rst,
    input raster_pos_t pos_i,
    input logic        phi_i,
    input logic        badline,
    input logic        aec_o
);

    // ----------------------------------------------------------------------
    // phi shape, rises at tick 16 and falls at tick 0
    // ----------------------------------------------------------------------
    a_phi_rise: assert property (@(posedge clk_dot4x) disable iff (rst)
        (pos_i.phase_tick == PHI_HIGH_TICK) |-> (phi_i && !$past(phi_i)))
        else $error("phi did not rise at tick 16");
    a_phi_low: assert property (@(posedge clk_dot4x) disable iff (rst)
        (pos_i.phase_tick == 5'd0) |-> !phi_i)
        else $error("phi high at tick 0");
    a_phi_steady: assert property (@(posedge clk_dot4x) disable iff (rst)
        ((pos_i.phase_tick != 5'd0) && (pos_i.phase_tick != PHI_HIGH_TICK))
        |-> (phi_i == $past(phi_i)))
        else $error("phi toggled away from a half cycle boundary");

    // ----------------------------------------------------------------------
    // bus ownership
    // ----------------------------------------------------------------------
    // cpu never owns the bus in the vic half
    a_aec_phi: assert property (@(posedge clk_dot4x) disable iff (rst)
        aec_o |-> phi_i)
        else $error("aec high while phi low");
    // char fetches hold the cpu off in the middle of a badline
    a_aec_badline: assert property (@(posedge clk_dot4x) disable iff (rst)
        (badline && phi_i && (pos_i.cycle_num >= 7'd16) && (pos_i.cycle_num <= 7'd53))
        |-> !aec_o)
        else $error("aec high during badline char fetch cycles");

endmodule

bind bus_arbiter vic_timing_props u_props (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .pos_i     (pos_i),
    .phi_i     (phi_i),
    .badline   (badline),
    .aec_o     (aec_o)
);

//--- verification/tb_vic_timing.sv
`timescale 1ns/1ps

module tb_vic_timing
    import vic_pkg::*;
();

    logic        clk_dot4x;
    logic        rst;
    chip_t       chip;
    logic        ce;
    logic        rw;
    logic [5:0]  adi;
    logic [7:0]  dbi;
    logic [7:0]  dbo;
    logic        phi;
    logic        irq;
    logic        ba;
    logic        aec;
    raster_pos_t pos;

    // reference model state, updated with the same edges as the DUT
    logic [4:0]  m_tick;
    logic        m_phi;
    logic [9:0]  m_x;
    logic [8:0]  m_line;
    logic [6:0]  m_ctrl1;
    logic [8:0]  m_cmp;
    logic        m_erst;
    logic        m_irst;
    logic        m_trig;
    logic        m_allow;
    logic        m_bad;
    logic        m_ba;
    logic        m_aec;
    logic [2:0]  m_casc;
    bit          model_live;
    logic [15:0] lfsr_state;
    int          checks;
    int          errors;

    vic_timing_top #(.BA_LEAD_PHASES(3)) DUT (
        .clk_dot4x (clk_dot4x), .rst (rst), .chip_i (chip), .ce_i (ce), .rw_i (rw),
        .adi_i (adi), .dbi_i (dbi), .dbo_o (dbo), .phi_o (phi), .irq_o (irq),
        .ba_o (ba), .aec_o (aec), .pos_o (pos)
    );

    always #5 clk_dot4x = ~clk_dot4x;

    // ----------------------------------------------------------------------
    // chip geometry and random source
    // ----------------------------------------------------------------------
    function automatic int x_max_of(input chip_t c);
        if (c == CHIP6567R8) return 519;
        if (c == CHIP6567R56A) return 511;
        return 503;
    endfunction

    function automatic int y_max_of(input chip_t c);
        if (c == CHIP6567R8) return 262;
        if (c == CHIP6567R56A) return 261;
        return 311;
    endfunction

    function automatic longint frame_ticks(input chip_t c);
        return longint'(y_max_of(c) + 1) * (x_max_of(c) + 1) * 4;
    endfunction

    // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | lfsr_state[0];
        end
    endtask

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    always @(posedge clk_dot4x) begin
        logic [4:0] t_next;
        logic       allow_n;
        logic       wr;
        if (rst) begin
            m_tick     <= '0;
            m_phi      <= 1'b0;
            m_x        <= '0;
            m_line     <= '0;
            m_ctrl1    <= '0;
            m_cmp      <= '0;
            m_erst     <= 1'b0;
            m_irst     <= 1'b0;
            m_trig     <= 1'b0;
            m_allow    <= 1'b0;
            m_bad      <= 1'b0;
            m_ba       <= 1'b1;
            m_aec      <= 1'b0;
            m_casc     <= 3'b111;
            model_live <= 1'b1;
        end else begin
            t_next = (m_tick == 5'd31) ? 5'd0 : m_tick + 5'd1;
            m_tick <= t_next;
            m_phi  <= (t_next >= 5'd16);
            // one dot per four ticks, line and frame wrap at the chip limits
            if (m_tick[1:0] == 2'b11) begin
                if (m_x >= 10'(x_max_of(chip))) begin
                    m_x    <= '0;
                    m_line <= (m_line >= 9'(y_max_of(chip))) ? 9'd0 : m_line + 9'd1;
                end else begin
                    m_x <= m_x + 10'd1;
                end
            end
            wr = (m_tick == 5'd28) && !ce && !rw;
            if (wr && adi == 6'h11) begin
                m_cmp[8] <= dbi[7];
                m_ctrl1  <= dbi[6:0];
            end
            if (wr && adi == 6'h12) m_cmp[7:0] <= dbi;
            if (wr && adi == 6'h1A) m_erst <= dbi[0];
            // once per matching line, sampled at tick 8 with phi low
            if (m_line != m_cmp) begin
                m_trig <= 1'b0;
            end else if (m_tick == 5'd8 && !m_phi && !m_trig) begin
                m_trig <= 1'b1;
                m_irst <= 1'b1;
            end
            if (wr && adi == 6'h19 && dbi[0]) m_irst <= 1'b0;
            if (m_tick == 5'd1) begin
                allow_n = m_allow;
                if (m_ctrl1[4] && m_line == 9'd48) allow_n = 1'b1;
                if (m_line == 9'd248) allow_n = 1'b0;
                m_allow <= allow_n;
                m_bad   <= allow_n && m_line >= 9'd48 && m_line <= 9'd247
                           && m_line[2:0] == m_ctrl1[2:0];
            end
            m_ba <= !(m_bad && m_x[9:3] >= 7'd12 && m_x[9:3] <= 7'd54);
            // a stage stays low only when ba was low at this phase end too
            if (m_tick == 5'd31 && m_phi) begin
                m_casc <= {m_casc[1] | m_ba, m_casc[0] | m_ba, m_ba};
            end
            m_aec <= (t_next >= 5'd16) && (m_ba || m_casc[2]);
        end
    end

    function automatic logic [7:0] read_expect(input logic [5:0] a);
        case (a)
            6'h11:   return {m_line[8], m_ctrl1};
            6'h12:   return m_line[7:0];
            6'h19:   return {m_irst & m_erst, 6'b111111, m_irst};
            6'h1A:   return {7'b1111111, m_erst};
            default: return 8'hFF;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // checks on the falling edge, away from the driving edge
    // ----------------------------------------------------------------------
    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("FAIL t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
        end
    endtask

    always @(negedge clk_dot4x) begin
        if (!rst && model_live) begin
            check_val("phi_o", m_phi, phi);
            check_val("pos_o.phase_tick", m_tick, pos.phase_tick);
            check_val("pos_o.raster_x", m_x, pos.raster_x);
            // eight dots per cpu cycle
            check_val("pos_o.cycle_num", m_x / 10'd8, pos.cycle_num);
            check_val("pos_o.raster_line", m_line, pos.raster_line);
            check_val("ba_o", m_ba, ba);
            check_val("aec_o", m_aec, aec);
            check_val("irq_o", m_irst & m_erst, irq);
            check_val("dbo_o", read_expect(adi), dbo);
        end
    end

    // ----------------------------------------------------------------------
    // stimulus, one bus access per phi cycle starting at tick 0
    // ----------------------------------------------------------------------
    task automatic run_chip(input chip_t c, input bit den_late);
        int           ysc, cmp, erst, clr_line, spare, sel, a;
        longint       n_ticks;
        bit           late_done, clr_done, match_done;
        logic [13:0]  q[$];
        logic [13:0]  w;
        logic [7:0]   ctrl1;
        @(posedge clk_dot4x);
        rst  <= 1'b1;
        chip <= c;
        ce   <= 1'b1;
        rw   <= 1'b1;
        repeat (2) @(posedge clk_dot4x);
        rst <= 1'b0;
        draw_bits(3, ysc);
        draw_bits(9, cmp);
        cmp = cmp % (y_max_of(c) + 1);
        draw_bits(1, erst);
        draw_bits(8, clr_line);
        draw_bits(3, spare);
        // den on from the start, or written only after line 48
        ctrl1 = {cmp[8], spare[2:1] == 2'b0 ? 2'b01 : 2'(spare[2:1]),
                 !den_late, spare[0], 3'(ysc)};
        q.push_back({6'h11, ctrl1});
        q.push_back({6'h12, 8'(cmp)});
        q.push_back({6'h1A, 7'b0, 1'(erst)});
        late_done  = 1'b0;
        clr_done   = 1'b0;
        match_done = 1'b0;
        n_ticks    = longint'(y_max_of(c) + 21) * (x_max_of(c) + 1) * 4;
        for (longint i = 0; i < n_ticks; i++) begin
            @(posedge clk_dot4x);
            if (m_tick == 5'd31) begin
                if (m_line == 9'd0) clr_done = 1'b0;
                if (den_late && !late_done && m_line == 9'd50) begin
                    ctrl1[4] = 1'b1;
                    q.push_back({6'h11, ctrl1});
                    late_done = 1'b1;
                end
                if (!clr_done && m_line == 9'(clr_line)) begin
                    q.push_back({6'h19, 8'h01});
                    clr_done = 1'b1;
                end
                // ack inside the matching line, the latch must stay clear after it
                if (!match_done && m_line == 9'(cmp)) begin
                    q.push_back({6'h19, 8'h01});
                    match_done = 1'b1;
                end
                if (q.size() > 0) begin
                    w = q.pop_front();
                    ce  <= 1'b0;
                    rw  <= 1'b0;
                    adi <= w[13:8];
                    dbi <= w[7:0];
                end else begin
                    draw_bits(3, sel);
                    draw_bits(6, a);
                    ce  <= 1'b0;
                    rw  <= 1'b1;
                    dbi <= 8'h00;
                    case (sel)
                        0: adi <= 6'h11;
                        1: adi <= 6'h12;
                        2: adi <= 6'h19;
                        3: adi <= 6'h1A;
                        default: adi <= 6'(a);
                    endcase
                end
            end
        end
    endtask

    initial begin
        clk_dot4x  = 1'b0;
        rst        = 1'b1;
        chip       = CHIP6569R5;
        ce         = 1'b1;
        rw         = 1'b1;
        adi        = 6'h00;
        dbi        = 8'h00;
        model_live = 1'b0;
        lfsr_state = 16'd68;
        checks     = 0;
        errors     = 0;
        // badlines on the first chip, den too late for any on the second
        run_chip(CHIP6569R5, 1'b0);
        run_chip(CHIP6567R8, 1'b1);
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // twice both frames, 10 ns per tick
    initial begin
        longint limit_ns;
        limit_ns = 2 * (frame_ticks(CHIP6569R5) + frame_ticks(CHIP6567R8)) * 10;
        #(limit_ns * 1ns);
        $display("watchdog expired before the runs completed");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- vic_timing.f
hw/vic_pkg.sv
hw/phase_gen.sv
hw/raster_counter.sv
hw/vic_registers.sv
hw/bus_arbiter.sv
hw/vic_timing_top.sv
verification/vic_timing_props.sv
verification/tb_vic_timing.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
TOP        ?= tb_vic_timing
RTL_TOP    ?= vic_timing_top
FILELIST   ?= vic_timing.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# output goes to the terminal and through grep; the grep status is the result
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "STATUS: PASS" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
